//--- include/arcade_consts.svh
//////////////////////////////
// Arcade input constants
// PS/2 fields, joystick bits and download indices
//////////////////////////////
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// PS/2 key word layout
`define PS2_TOGGLE_BIT  10
`define PS2_PRESSED_BIT 9
`define PS2_CODE_W      8

// Joystick word width
`define JOY_W 16

// Joystick button positions
`define JOY_RIGHT  0
`define JOY_LEFT   1
`define JOY_DOWN   2
`define JOY_UP     3
`define JOY_SW1    4
`define JOY_SW2    5
`define JOY_START1 6
`define JOY_COIN   7
`define JOY_START2 8
`define JOY_PAUSE  9

// Download stream
`define DL_INDEX_DSW  8'd254
`define DL_INDEX_GAME 8'd1
`define DL_ADDR_W     25

// Only the first two DIP banks are read by the board
`define DSW_COUNT 2

`endif

//--- verilog/arcade_pkg.sv
//////////////////////////////
// Arcade input types
// Scan codes, held keys and pause states
//////////////////////////////
`include "arcade_consts.svh"

package arcade_pkg;

	// Recognised keyboard scan codes
	typedef enum logic [`PS2_CODE_W-1:0] {
		SC_START1 = 8'h16,
		SC_START2 = 8'h1E,
		SC_COIN1  = 8'h2E,
		SC_COIN2  = 8'h36,
		SC_PAUSE  = 8'h4D,
		SC_UP     = 8'h75,
		SC_DOWN   = 8'h72,
		SC_LEFT   = 8'h6B,
		SC_RIGHT  = 8'h74,
		SC_SW1    = 8'h14,
		SC_SW2    = 8'h11
	} scan_code_e;

	// Held key flags
	// High while the key is down
	typedef struct packed {
		logic start1;
		logic start2;
		logic coin1;
		logic coin2;
		logic pause;
		logic up;
		logic down;
		logic left;
		logic right;
		logic sw1;
		logic sw2;
	} key_state_t;

	// Pause FSM states
	typedef enum logic {
		RUNNING = 1'b0,
		PAUSED  = 1'b1
	} pause_state_e;

endpackage

//--- verilog/key_bus_if.sv
//////////////////////////////
// Held-key bus
// Decoder to mapper
//////////////////////////////
`timescale 1ns/1ps

interface key_bus_if
	import arcade_pkg::*;
();

	// Level valid every cycle
	// No handshake
	key_state_t keys;

	// Decoder side
	modport source (output keys);

	// Mapper side
	modport sink (input keys);

endinterface

//--- verilog/key_decoder.sv
//////////////////////////////
// PS/2 key decoder
// Turns key events into held-key flags
//////////////////////////////
`timescale 1ns/1ps
`include "arcade_consts.svh"

module key_decoder
	import arcade_pkg::*;
(
	input  logic        MS_CLK,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	key_bus_if.source   key_out
);

	// Last seen event toggle
	logic       toggle_q;
	key_state_t keys_q;
	logic       new_event;
	logic       pressed;
	scan_code_e code;

	// Host flips the toggle bit once per event
	assign new_event = ps2_key[`PS2_TOGGLE_BIT] != toggle_q;
	assign pressed   = ps2_key[`PS2_PRESSED_BIT];
	assign code      = scan_code_e'(ps2_key[`PS2_CODE_W-1:0]);

	//////////////////////////////
	// Event capture
	//////////////////////////////
	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			toggle_q <= 1'b0;
			keys_q   <= '0;
		end else if (new_event) begin
			toggle_q <= ps2_key[`PS2_TOGGLE_BIT];
			// Press sets and release clears
			case (code)
				SC_START1: keys_q.start1 <= pressed;
				SC_START2: keys_q.start2 <= pressed;
				SC_COIN1:  keys_q.coin1  <= pressed;
				SC_COIN2:  keys_q.coin2  <= pressed;
				SC_PAUSE:  keys_q.pause  <= pressed;
				SC_UP:     keys_q.up     <= pressed;
				SC_DOWN:   keys_q.down   <= pressed;
				SC_LEFT:   keys_q.left   <= pressed;
				SC_RIGHT:  keys_q.right  <= pressed;
				SC_SW1:    keys_q.sw1    <= pressed;
				SC_SW2:    keys_q.sw2    <= pressed;
				// Unknown codes leave all flags alone
				default: ;
			endcase
		end
	end

	// Held flags out to the mapper
	assign key_out.keys = keys_q;

endmodule

//--- verilog/config_capture.sv
//////////////////////////////
// Configuration capture
// DIP banks and game byte from download
//////////////////////////////
`timescale 1ns/1ps
`include "arcade_consts.svh"

module config_capture (
	input  logic                  MS_CLK,
	input  logic                  reset,
	input  logic                  ioctl_wr,
	input  logic [7:0]            ioctl_index,
	input  logic [`DL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	output logic [7:0]            dsw1,
	output logic [7:0]            dsw2,
	output logic [7:0]            game
);

	// Kept DIP banks
	logic [7:0] dsw_q [`DSW_COUNT];
	logic       dsw_wr;
	logic       game_wr;

	// DIP write in the low bank window
	assign dsw_wr = ioctl_wr && (ioctl_index == `DL_INDEX_DSW) &&
		(ioctl_addr[`DL_ADDR_W-1:3] == '0);

	// Game select sits at address 0
	assign game_wr = ioctl_wr && (ioctl_index == `DL_INDEX_GAME) && (ioctl_addr == '0);

	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			for (int i = 0; i < `DSW_COUNT; i++) begin
				dsw_q[i] <= 8'h00;
			end
			game <= 8'h00;
		end else begin
			// Banks past the kept count are dropped
			for (int i = 0; i < `DSW_COUNT; i++) begin
				if (dsw_wr && (ioctl_addr[2:0] == 3'(i))) begin
					dsw_q[i] <= ioctl_dout;
				end
			end
			if (game_wr) begin
				game <= ioctl_dout;
			end
		end
	end

	assign dsw1 = dsw_q[0];
	assign dsw2 = dsw_q[1];

endmodule

//--- verilog/control_mapper.sv
//////////////////////////////
// Control mapper
// Keys and joysticks to player bytes
//////////////////////////////
`timescale 1ns/1ps
`include "arcade_consts.svh"

module control_mapper
	import arcade_pkg::*;
(
	input  logic              MS_CLK,
	input  logic              reset,
	key_bus_if.sink           keys_in,
	input  logic [`JOY_W-1:0] joystick_0,
	input  logic [`JOY_W-1:0] joystick_1,
	output logic [7:0]        player1,
	output logic [7:0]        player2,
	output logic              pause_level
);

	key_state_t        k;
	logic [`JOY_W-1:0] joy_any;
	// Active high before the final inversion
	logic [7:0]        p1_held;
	logic [7:0]        p2_held;
	logic              pause_held;

	assign k       = keys_in.keys;
	assign joy_any = joystick_0 | joystick_1;

	//////////////////////////////
	// Player 1 byte
	//////////////////////////////
	// Starts are shared by both sticks
	assign p1_held = {
		k.start2 | joy_any[`JOY_START2],
		k.start1 | joy_any[`JOY_START1],
		k.sw2    | joystick_0[`JOY_SW2],
		k.sw1    | joystick_0[`JOY_SW1],
		k.down   | joystick_0[`JOY_DOWN],
		k.up     | joystick_0[`JOY_UP],
		k.left   | joystick_0[`JOY_LEFT],
		k.right  | joystick_0[`JOY_RIGHT]
	};

	//////////////////////////////
	// Player 2 byte
	//////////////////////////////
	// Coins come one per stick
	assign p2_held = {
		k.coin2 | joystick_1[`JOY_COIN],
		k.coin1 | joystick_0[`JOY_COIN],
		k.sw2   | joystick_1[`JOY_SW2],
		k.sw1   | joystick_1[`JOY_SW1],
		k.down  | joystick_1[`JOY_DOWN],
		k.up    | joystick_1[`JOY_UP],
		k.left  | joystick_1[`JOY_LEFT],
		k.right | joystick_1[`JOY_RIGHT]
	};

	assign pause_held = k.pause | joy_any[`JOY_PAUSE];

	// Board lines are active low
	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			player1     <= 8'hFF;
			player2     <= 8'hFF;
			pause_level <= 1'b0;
		end else begin
			player1     <= ~p1_held;
			player2     <= ~p2_held;
			pause_level <= pause_held;
		end
	end

endmodule

//--- verilog/pause_control.sv
//////////////////////////////
// Pause control
// Button toggle plus menu pause
//////////////////////////////
`timescale 1ns/1ps

module pause_control
	import arcade_pkg::*;
(
	input  logic MS_CLK,
	input  logic reset,
	input  logic pause_level,
	input  logic pause_in_osd,
	input  logic osd_status,
	output logic pause_cpu
);

	pause_state_e state;
	// Previous level for edge detect
	logic         level_q;
	logic         level_rise;

	assign level_rise = pause_level && !level_q;

	//////////////////////////////
	// Toggle FSM
	//////////////////////////////
	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			state   <= RUNNING;
			level_q <= 1'b0;
		end else begin
			level_q <= pause_level;
			if (level_rise) begin
				state <= (state == PAUSED) ? RUNNING : PAUSED;
			end
		end
	end

	// Menu pause applies only while the OSD is open
	assign pause_cpu = (state == PAUSED) || (pause_in_osd && osd_status);

endmodule

//--- verilog/arcade_inputs_top.sv
//////////////////////////////
// Arcade input front end
// Keyboard, joysticks, DIP and pause
//////////////////////////////
`timescale 1ns/1ps
`include "arcade_consts.svh"

module arcade_inputs_top (
	input  logic                  MS_CLK,
	input  logic                  reset,
	input  logic [10:0]           ps2_key,
	input  logic [`JOY_W-1:0]     joystick_0,
	input  logic [`JOY_W-1:0]     joystick_1,
	input  logic                  ioctl_wr,
	input  logic [7:0]            ioctl_index,
	input  logic [`DL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	input  logic                  pause_in_osd,
	input  logic                  osd_status,
	output logic [7:0]            player1,
	output logic [7:0]            player2,
	output logic [7:0]            dsw1,
	output logic [7:0]            dsw2,
	output logic [7:0]            game,
	output logic                  pause_cpu
);

	// Registered pause request from the mapper
	logic pause_level;

	key_bus_if key_bus ();

	// Decode stage
	key_decoder i_key_decoder (
		.MS_CLK  (MS_CLK),
		.reset   (reset),
		.ps2_key (ps2_key),
		.key_out (key_bus.source)
	);

	config_capture i_config_capture (
		.MS_CLK      (MS_CLK),
		.reset       (reset),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dsw1        (dsw1),
		.dsw2        (dsw2),
		.game        (game)
	);

	// Merge stage
	control_mapper i_control_mapper (
		.MS_CLK      (MS_CLK),
		.reset       (reset),
		.keys_in     (key_bus.sink),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.player1     (player1),
		.player2     (player2),
		.pause_level (pause_level)
	);

	// Pause request
	pause_control i_pause_control (
		.MS_CLK       (MS_CLK),
		.reset        (reset),
		.pause_level  (pause_level),
		.pause_in_osd (pause_in_osd),
		.osd_status   (osd_status),
		.pause_cpu    (pause_cpu)
	);

endmodule

//--- tb/tb_arcade_inputs.sv
//////////////////////////////
// Arcade input front end testbench
// Table-driven checks of keys, sticks, DIP and pause
//////////////////////////////
`timescale 1ns/1ps
`include "arcade_consts.svh"

module tb_arcade_inputs;

	localparam int HALF_PERIOD  = 2;
	localparam int SETTLE_LIMIT = 16;

	// Row kinds with their own settle counts
	typedef enum logic [1:0] {OP_JOY, OP_PS2, OP_DL, OP_PAUSE} op_e;

	typedef struct packed {
		op_e                   op;
		logic [10:0]           ps2;
		logic [`JOY_W-1:0]     joy0;
		logic [`JOY_W-1:0]     joy1;
		logic [7:0]            idx;
		logic [`DL_ADDR_W-1:0] addr;
		logic [7:0]            data;
		// pause_in_osd, osd_status
		logic [1:0]            osd;
		logic [7:0]            exp_p1;
		logic [7:0]            exp_p2;
		logic [7:0]            exp_dsw1;
		logic [7:0]            exp_dsw2;
		logic [7:0]            exp_game;
		logic                  exp_pause;
	} row_t;

	logic                  MS_CLK;
	logic                  reset;
	logic [10:0]           ps2_key;
	logic [`JOY_W-1:0]     joystick_0;
	logic [`JOY_W-1:0]     joystick_1;
	logic                  ioctl_wr;
	logic [7:0]            ioctl_index;
	logic [`DL_ADDR_W-1:0] ioctl_addr;
	logic [7:0]            ioctl_dout;
	logic                  pause_in_osd;
	logic                  osd_status;
	logic [7:0]            player1;
	logic [7:0]            player2;
	logic [7:0]            dsw1;
	logic [7:0]            dsw2;
	logic [7:0]            game;
	logic                  pause_cpu;

	row_t   stim_q[$];
	// Expected outputs of the row applied before
	row_t   last_row;
	integer seed;

	arcade_inputs_top i_arcade_inputs_top (
		.MS_CLK       (MS_CLK),
		.reset        (reset),
		.ps2_key      (ps2_key),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.ioctl_wr     (ioctl_wr),
		.ioctl_index  (ioctl_index),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.pause_in_osd (pause_in_osd),
		.osd_status   (osd_status),
		.player1      (player1),
		.player2      (player2),
		.dsw1         (dsw1),
		.dsw2         (dsw2),
		.game         (game),
		.pause_cpu    (pause_cpu)
	);

	// 4 ns clock with the first rise at 2 ns
	initial begin
		MS_CLK = 1'b0;
		forever #HALF_PERIOD MS_CLK = ~MS_CLK;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////
	// Starts from either stick and the rest from stick 0 with lines active low
	function automatic logic [7:0] expect_p1(input logic [`JOY_W-1:0] j0,
		input logic [`JOY_W-1:0] j1);
		return ~{j0[`JOY_START2] | j1[`JOY_START2], j0[`JOY_START1] | j1[`JOY_START1],
			j0[`JOY_SW2], j0[`JOY_SW1], j0[`JOY_DOWN], j0[`JOY_UP],
			j0[`JOY_LEFT], j0[`JOY_RIGHT]};
	endfunction

	// One coin per stick and the rest from stick 1
	function automatic logic [7:0] expect_p2(input logic [`JOY_W-1:0] j0,
		input logic [`JOY_W-1:0] j1);
		return ~{j1[`JOY_COIN], j0[`JOY_COIN], j1[`JOY_SW2], j1[`JOY_SW1],
			j1[`JOY_DOWN], j1[`JOY_UP], j1[`JOY_LEFT], j1[`JOY_RIGHT]};
	endfunction

	task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s got %h expected %h",
				$time, what, actual, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// Polls at odd times clear of every clock toggle
	task automatic wait_edges(input int n);
		int   seen;
		int   polls;
		logic prev;
		seen  = 0;
		polls = 0;
		prev  = MS_CLK;
		while (seen < n) begin
			if (polls >= SETTLE_LIMIT) begin
				$display("Timeout: clock stopped while waiting for %0d rising edges", n);
				$display("Test failed");
				$fatal(1);
			end
			#HALF_PERIOD;
			polls++;
			if (!prev && MS_CLK) begin
				seen++;
			end
			prev = MS_CLK;
		end
	endtask

	task automatic add_row(input op_e op, input logic [10:0] ps2,
		input logic [`JOY_W-1:0] j0, input logic [`JOY_W-1:0] j1,
		input logic [7:0] idx, input logic [`DL_ADDR_W-1:0] addr, input logic [7:0] data,
		input logic [1:0] osd, input logic [7:0] p1, input logic [7:0] p2,
		input logic [7:0] d1, input logic [7:0] d2, input logic [7:0] g, input logic pc);
		stim_q.push_back('{op, ps2, j0, j1, idx, addr, data, osd, p1, p2, d1, d2, g, pc});
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////
	task automatic build_table();
		logic [`JOY_W-1:0] j0;
		logic [`JOY_W-1:0] j1;
		seed = 32'habee7cb9;
		// Random sticks with no keys and the pause bit clear
		for (int i = 0; i < 8; i++) begin
			j0 = 16'($random(seed)) & ~(16'd1 << `JOY_PAUSE);
			j1 = 16'($random(seed)) & ~(16'd1 << `JOY_PAUSE);
			add_row(OP_JOY, 11'h000, j0, j1, 8'h00, 25'h0, 8'h00, 2'b00,
				expect_p1(j0, j1), expect_p2(j0, j1), 8'h00, 8'h00, 8'h00, 1'b0);
		end
		add_row(OP_JOY, 11'h000, 16'h0000, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b00,
			8'hFF, 8'hFF, 8'h00, 8'h00, 8'h00, 1'b0);
		// UP press on a new toggle
		add_row(OP_PS2, 11'h675, 16'h0000, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b00,
			8'hFB, 8'hFB, 8'h00, 8'h00, 8'h00, 1'b0);
		// Toggle unchanged so no event
		add_row(OP_PS2, 11'h475, 16'h0000, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b00,
			8'hFB, 8'hFB, 8'h00, 8'h00, 8'h00, 1'b0);
		// Unknown code 1C
		add_row(OP_PS2, 11'h21C, 16'h0000, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b00,
			8'hFB, 8'hFB, 8'h00, 8'h00, 8'h00, 1'b0);
		// UP release
		add_row(OP_PS2, 11'h475, 16'h0000, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b00,
			8'hFF, 8'hFF, 8'h00, 8'h00, 8'h00, 1'b0);
		// DIP banks 0 and 1
		add_row(OP_DL, 11'h475, 16'h0000, 16'h0000, 8'hFE, 25'h0, 8'hA5, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h00, 8'h00, 1'b0);
		add_row(OP_DL, 11'h475, 16'h0000, 16'h0000, 8'hFE, 25'h1, 8'h3C, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h00, 1'b0);
		// Upper address set
		add_row(OP_DL, 11'h475, 16'h0000, 16'h0000, 8'hFE, 25'h8, 8'h77, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h00, 1'b0);
		// Bank 2 is not kept
		add_row(OP_DL, 11'h475, 16'h0000, 16'h0000, 8'hFE, 25'h2, 8'h99, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h00, 1'b0);
		// Other index
		add_row(OP_DL, 11'h475, 16'h0000, 16'h0000, 8'hFD, 25'h0, 8'h11, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h00, 1'b0);
		// Game byte then a write off address 0
		add_row(OP_DL, 11'h475, 16'h0000, 16'h0000, 8'h01, 25'h0, 8'h42, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b0);
		add_row(OP_DL, 11'h475, 16'h0000, 16'h0000, 8'h01, 25'h1, 8'h55, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b0);
		// Pause press, release, press, release
		add_row(OP_PAUSE, 11'h475, 16'h0200, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b1);
		add_row(OP_PAUSE, 11'h475, 16'h0000, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b1);
		add_row(OP_PAUSE, 11'h475, 16'h0200, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b0);
		add_row(OP_PAUSE, 11'h475, 16'h0000, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b00,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b0);
		// Menu pause over both toggle states
		add_row(OP_PAUSE, 11'h475, 16'h0000, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b11,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b1);
		add_row(OP_PAUSE, 11'h475, 16'h0200, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b11,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b1);
		add_row(OP_PAUSE, 11'h475, 16'h0000, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b10,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b1);
		add_row(OP_PAUSE, 11'h475, 16'h0200, 16'h0000, 8'h00, 25'h0, 8'h00, 2'b01,
			8'hFF, 8'hFF, 8'hA5, 8'h3C, 8'h42, 1'b0);
	endtask

	task automatic apply_row(input int n, input row_t r);
		int settle;
		settle       = (r.op == OP_PS2 || r.op == OP_PAUSE) ? 2 : 1;
		ps2_key      = r.ps2;
		joystick_0   = r.joy0;
		joystick_1   = r.joy1;
		ioctl_wr     = (r.op == OP_DL);
		ioctl_index  = r.idx;
		ioctl_addr   = r.addr;
		ioctl_dout   = r.data;
		pause_in_osd = r.osd[1];
		osd_status   = r.osd[0];
		if (settle == 2) begin
			wait_edges(1);
			// First edge only loads the key flags and the pause level
			check_value(player1, last_row.exp_p1, $sformatf("row %0d player1 early", n));
			check_value(player2, last_row.exp_p2, $sformatf("row %0d player2 early", n));
			if (r.osd == last_row.osd) begin
				check_value({7'd0, pause_cpu}, {7'd0, last_row.exp_pause},
					$sformatf("row %0d pause_cpu early", n));
			end
		end
		wait_edges(1);
		// Single-cycle write strobe
		ioctl_wr = 1'b0;
		check_value(player1, r.exp_p1, $sformatf("row %0d player1", n));
		check_value(player2, r.exp_p2, $sformatf("row %0d player2", n));
		check_value(dsw1, r.exp_dsw1, $sformatf("row %0d dsw1", n));
		check_value(dsw2, r.exp_dsw2, $sformatf("row %0d dsw2", n));
		check_value(game, r.exp_game, $sformatf("row %0d game", n));
		check_value({7'd0, pause_cpu}, {7'd0, r.exp_pause}, $sformatf("row %0d pause_cpu", n));
		last_row = r;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		reset        = 1'b1;
		ps2_key      = '0;
		joystick_0   = '0;
		joystick_1   = '0;
		ioctl_wr     = 1'b0;
		ioctl_index  = '0;
		ioctl_addr   = '0;
		ioctl_dout   = '0;
		pause_in_osd = 1'b0;
		osd_status   = 1'b0;
		build_table();
		// Reset values stand in for the row before the first
		last_row        = '0;
		last_row.exp_p1 = 8'hFF;
		last_row.exp_p2 = 8'hFF;
		// Off the toggle grid then hold reset for 4 edges
		#1;
		wait_edges(4);
		reset = 1'b0;
		check_value(player1, 8'hFF, "reset player1");
		check_value(player2, 8'hFF, "reset player2");
		check_value(dsw1, 8'h00, "reset dsw1");
		check_value(dsw2, 8'h00, "reset dsw2");
		check_value(game, 8'h00, "reset game");
		check_value({7'd0, pause_cpu}, 8'h00, "reset pause_cpu");
		foreach (stim_q[i]) begin
			apply_row(i, stim_q[i]);
		end
		$display("Test passed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
verilog/arcade_pkg.sv
verilog/key_bus_if.sv
verilog/key_decoder.sv
verilog/config_capture.sv
verilog/control_mapper.sv
verilog/pause_control.sv
verilog/arcade_inputs_top.sv
tb/tb_arcade_inputs.sv

//--- Makefile
# Verilator build and run of the arcade input front end testbench

SIM_LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module tb_arcade_inputs -o sim_tb

run: compile
	-./obj_dir/sim_tb > $(SIM_LOG) 2>&1
	cat $(SIM_LOG)
	@if grep -q "Test failed" $(SIM_LOG); then exit 1; fi
	@grep -q "Test passed" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
